// File: source/mem_pkg.sv
package mem_pkg;

	// --------------------
	// Memory side
	// --------------------

	// Word address into the burst memory
	localparam int ADDR_W = 22;

	// Memory word and register bus data width
	localparam int DATA_W = 32;

	// One write burst, also the size of one line bank
	localparam int BURST_WORDS = 128;

	// Burst counter width, shared by the target and the done count
	localparam int CNT_W = 16;

	// Command toward the memory, held until ready
	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
	} mem_req_s;

	// --------------------
	// Register bus
	// --------------------

	localparam int REG_AW = 2;

	localparam logic [REG_AW-1:0] REG_CSR  = 2'd0;
	localparam logic [REG_AW-1:0] REG_BASE = 2'd1;

	// Master side of the bus, held steady until ack
	typedef struct packed {
		logic              cyc;
		logic              we;
		logic [REG_AW-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} reg_bus_s;

	// CSR write: start flag and target burst count
	typedef struct packed {
		logic                      start;
		logic [DATA_W-CNT_W-2:0]   rsvd;
		logic [CNT_W-1:0]          target;
	} csr_cmd_s;

	// Base address write, upper bits ignored
	typedef struct packed {
		logic [DATA_W-ADDR_W-1:0]  pad;
		logic [ADDR_W-1:0]         addr;
	} base_addr_s;

	// Same write word, decoded by register address
	typedef union packed {
		csr_cmd_s   csr;
		base_addr_s base;
	} bus_wdata_u;

endpackage

// File: source/cap_pkg.sv
package cap_pkg;

	// --------------------
	// Video stream
	// --------------------

	// One byte per clock
	localparam int PIXEL_W = 8;

	// Fixed part of every timing code
	localparam logic [3*PIXEL_W-1:0] SYNC_PREAMBLE = 24'hff0000;

	// Code bytes after the preamble
	localparam logic [PIXEL_W-1:0] SYNC_VBLANK = 8'hb6;
	localparam logic [PIXEL_W-1:0] SYNC_ACTIVE = 8'h9d;

	// --------------------
	// Line banks
	// --------------------

	// Ping-pong by default, four also works
	localparam int NUM_BANKS = 2;

	// A bank drains as exactly one burst
	localparam int BANK_WORDS = mem_pkg::BURST_WORDS;
	localparam int BANK_AW    = 7;

	localparam int BANK_SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

	// Packed word geometry
	localparam int WORD_W       = mem_pkg::DATA_W;
	localparam int PIX_PER_WORD = WORD_W / PIXEL_W;
	localparam int PIX_CNT_W    = $clog2(PIX_PER_WORD);

	// Write port shared by all banks, one enable bit each
	typedef struct packed {
		logic [NUM_BANKS-1:0] en;
		logic [BANK_AW-1:0]   addr;
		logic [WORD_W-1:0]    data;
	} bank_wr_s;

endpackage

// File: source/line_bank.sv
`timescale 1ns/1ps

module line_bank #(
	parameter int BANK_ID = 0
) (
	input  logic                          clk,
	input  logic                          cap_run,
	input  cap_pkg::bank_wr_s             wr,
	input  logic [cap_pkg::BANK_AW-1:0]   rd_addr,
	input  logic                          rd_ena,
	input  logic                          release_req,
	output logic [cap_pkg::WORD_W-1:0]    rd_data,
	output logic                          full
);
	import cap_pkg::*;

	logic [WORD_W-1:0] mem [BANK_WORDS];
	logic              we;

	// Own lane of the shared write port
	assign we = wr.en[BANK_ID];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr.addr] <= wr.data;
	end

	// Registered read, one cycle latency
	always_ff @(posedge clk)
	begin
		if (rd_ena)
			rd_data <= mem[rd_addr];
	end

	// Full from the last word until the flush engine lets go
	always_ff @(posedge clk or negedge cap_run)
	begin
		if (!cap_run)
			full <= 1'b0;
		else if (release_req)
			full <= 1'b0;
		else if (we && (wr.addr == BANK_AW'(BANK_WORDS - 1)))
			full <= 1'b1;
	end

endmodule

// File: source/sync_capture.sv
`timescale 1ns/1ps

module sync_capture (
	input  logic                          clk,
	input  logic                          cap_run,
	input  logic                          capturing,
	input  logic [cap_pkg::PIXEL_W-1:0]   vid_data,
	input  logic [cap_pkg::NUM_BANKS-1:0] bank_full,
	output cap_pkg::bank_wr_s             bank_wr,
	output logic                          overrun
);
	import cap_pkg::*;

	// Newest byte sits in the low bits
	logic [WORD_W-1:0]     hist;
	logic                  vblank_hit;
	logic                  active_hit;
	logic                  armed;
	logic                  active;
	logic                  go;
	logic [PIX_CNT_W-1:0]  pix_cnt;
	logic                  word_rdy;
	logic [BANK_AW-1:0]    wr_addr;
	logic [BANK_SEL_W-1:0] wr_sel;
	logic                  drop;

	// --------------------
	// Timing code detect
	// --------------------

	always_ff @(posedge clk)
		hist <= {hist[WORD_W-PIXEL_W-1:0], vid_data};

	assign vblank_hit = (hist == {SYNC_PREAMBLE, SYNC_VBLANK});
	assign active_hit = (hist == {SYNC_PREAMBLE, SYNC_ACTIVE});

	// First data byte is the one right after the active code
	assign go = capturing & (active | (armed & active_hit));

	always_ff @(posedge clk or negedge cap_run)
	begin
		if (!cap_run)
		begin
			armed   <= 1'b0;
			active  <= 1'b0;
			overrun <= 1'b0;
		end
		else if (!capturing)
		begin
			armed   <= 1'b0;
			active  <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			armed   <= armed | vblank_hit;
			active  <= active | (armed & active_hit);
			overrun <= overrun | drop;
		end
	end

	// --------------------
	// Packing and bank walk
	// --------------------

	always_ff @(posedge clk or negedge cap_run)
	begin
		if (!cap_run)
		begin
			pix_cnt  <= '0;
			word_rdy <= 1'b0;
			wr_addr  <= '0;
			wr_sel   <= '0;
		end
		else if (!capturing)
		begin
			pix_cnt  <= '0;
			word_rdy <= 1'b0;
			wr_addr  <= '0;
			wr_sel   <= '0;
		end
		else
		begin
			word_rdy <= go && (pix_cnt == PIX_CNT_W'(PIX_PER_WORD - 1));
			if (go)
				pix_cnt <= pix_cnt + 1'b1;
			// Address moves on even when the word is dropped
			if (word_rdy)
			begin
				wr_addr <= wr_addr + 1'b1;
				if (wr_addr == BANK_AW'(BANK_WORDS - 1))
					wr_sel <= (wr_sel == BANK_SEL_W'(NUM_BANKS - 1)) ? '0 : wr_sel + 1'b1;
			end
		end
	end

	assign drop = word_rdy & bank_full[wr_sel];

	// Oldest byte of the history goes to bits 7:0
	always_comb
	begin
		bank_wr.en         = '0;
		bank_wr.en[wr_sel] = word_rdy & ~bank_full[wr_sel];
		bank_wr.addr       = wr_addr;
		for (int i = 0; i < PIX_PER_WORD; i++)
			bank_wr.data[i*PIXEL_W +: PIXEL_W] = hist[(PIX_PER_WORD-1-i)*PIXEL_W +: PIXEL_W];
	end

endmodule

// File: source/burst_flush.sv
`timescale 1ns/1ps

module burst_flush (
	input  logic                                               clk,
	input  logic                                               cap_run,
	input  logic                                               start_pulse,
	input  logic [mem_pkg::ADDR_W-1:0]                         base_addr,
	input  logic [mem_pkg::CNT_W-1:0]                          target,
	input  logic [cap_pkg::NUM_BANKS-1:0]                      bank_full,
	input  logic [cap_pkg::NUM_BANKS-1:0][mem_pkg::DATA_W-1:0] bank_rd_data,
	output logic [cap_pkg::BANK_AW-1:0]                        rd_addr,
	output logic                                               rd_ena,
	output logic [cap_pkg::NUM_BANKS-1:0]                      release_req,
	output mem_pkg::mem_req_s                                  mem_req,
	input  logic                                               mem_ready,
	output logic [mem_pkg::DATA_W-1:0]                         mem_wdata,
	input  logic                                               mem_wack,
	input  logic                                               mem_wlast,
	output logic [mem_pkg::CNT_W-1:0]                          bursts_done,
	output logic                                               done_pulse
);
	import cap_pkg::*;
	import mem_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_FULL,	// next bank in order not yet full
		ST_CMD,
		ST_DATA
	} state_e;

	state_e                state;
	state_e                state_nxt;
	logic [BANK_SEL_W-1:0] sel;
	logic [ADDR_W-1:0]     cur_addr;
	logic                  prefetch;
	logic                  burst_end;
	logic                  last_burst;

	assign prefetch   = (state == ST_WAIT_FULL) & bank_full[sel];
	assign burst_end  = (state == ST_DATA) & mem_wack & mem_wlast;
	assign last_burst = burst_end & ((bursts_done + 1'b1) == target);

	// --------------------
	// FSM
	// --------------------

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_WAIT_FULL:
				if (bank_full[sel])
					state_nxt = ST_CMD;
			ST_CMD:
				if (mem_ready)
					state_nxt = ST_DATA;
			ST_DATA:
				if (burst_end)
					state_nxt = last_burst ? ST_IDLE : ST_WAIT_FULL;
			default:
				state_nxt = state;
		endcase
		// A new start always restarts from the first bank
		if (start_pulse)
			state_nxt = ST_WAIT_FULL;
	end

	always_ff @(posedge clk or negedge cap_run)
	begin
		if (!cap_run)
		begin
			state       <= ST_IDLE;
			sel         <= '0;
			cur_addr    <= '0;
			rd_addr     <= '0;
			bursts_done <= '0;
			done_pulse  <= 1'b0;
		end
		else
		begin
			state      <= state_nxt;
			done_pulse <= last_burst;
			if (start_pulse)
			begin
				sel         <= '0;
				cur_addr    <= base_addr;
				rd_addr     <= '0;
				bursts_done <= '0;
			end
			else
			begin
				// Word 0 is read ahead, every wack then fetches the next one
				if (burst_end)
					rd_addr <= '0;
				else if (prefetch || ((state == ST_DATA) && mem_wack))
					rd_addr <= rd_addr + 1'b1;

				if (burst_end)
				begin
					cur_addr    <= cur_addr + ADDR_W'(BURST_WORDS);
					bursts_done <= bursts_done + 1'b1;
					sel         <= (sel == BANK_SEL_W'(NUM_BANKS - 1)) ? '0 : sel + 1'b1;
				end
			end
		end
	end

	// --------------------
	// Outputs
	// --------------------

	assign rd_ena = prefetch | ((state == ST_DATA) & mem_wack);

	assign mem_req.valid = (state == ST_CMD);
	assign mem_req.addr  = cur_addr;

	assign mem_wdata = bank_rd_data[sel];

	always_comb
	begin
		release_req      = '0;
		release_req[sel] = burst_end;
	end

endmodule

// File: source/cap_regs.sv
`timescale 1ns/1ps

module cap_regs (
	input  logic                       clk,
	input  logic                       cap_run,
	input  mem_pkg::reg_bus_s          bus,
	output logic [mem_pkg::DATA_W-1:0] rdata,
	output logic                       ack,
	input  logic [mem_pkg::CNT_W-1:0]  bursts_done,
	input  logic                       overrun,
	input  logic                       done_pulse,
	output logic                       capturing,
	output logic                       start_pulse,
	output logic [mem_pkg::ADDR_W-1:0] base_addr,
	output logic [mem_pkg::CNT_W-1:0]  target
);
	import mem_pkg::*;

	bus_wdata_u wd;
	logic       wr_csr;
	logic       wr_base;

	assign wd = bus.wdata;

	// Two-cycle access, ack for one cycle
	always_ff @(posedge clk or negedge cap_run)
	begin
		if (!cap_run)
			ack <= 1'b0;
		else
			ack <= bus.cyc & ~ack;
	end

	// Writes land on the ack cycle
	assign wr_csr      = ack & bus.cyc & bus.we & (bus.addr == REG_CSR);
	assign wr_base     = ack & bus.cyc & bus.we & (bus.addr == REG_BASE);
	assign start_pulse = wr_csr & wd.csr.start;

	always_ff @(posedge clk or negedge cap_run)
	begin
		if (!cap_run)
		begin
			capturing <= 1'b0;
			base_addr <= '0;
			target    <= '0;
		end
		else
		begin
			capturing <= (capturing & ~done_pulse) | start_pulse;
			if (wr_csr)
				target <= wd.csr.target;
			if (wr_base)
				base_addr <= wd.base.addr;
		end
	end

	// Status word: busy, overrun, bursts done
	always_comb
	begin
		rdata = '0;
		if (ack)
		begin
			if (bus.addr == REG_CSR)
				rdata = {capturing, overrun, {(DATA_W-CNT_W-2){1'b0}}, bursts_done};
			else if (bus.addr == REG_BASE)
				rdata = {{(DATA_W-ADDR_W){1'b0}}, base_addr};
		end
	end

endmodule

// File: source/vid_cap_top.sv
`timescale 1ns/1ps

module vid_cap_top (
	input  logic                        clk,
	input  logic                        cap_run,
	input  logic [cap_pkg::PIXEL_W-1:0] vid_data,
	input  mem_pkg::reg_bus_s           bus,
	output logic [mem_pkg::DATA_W-1:0]  rdata,
	output logic                        ack,
	output mem_pkg::mem_req_s           mem_req,
	input  logic                        mem_ready,
	output logic [mem_pkg::DATA_W-1:0]  mem_wdata,
	input  logic                        mem_wack,
	input  logic                        mem_wlast
);
	import cap_pkg::*;
	import mem_pkg::*;

	// Control between registers and engines
	logic                              capturing;
	logic                              start_pulse;
	logic                              done_pulse;
	logic                              overrun;
	logic [ADDR_W-1:0]                 base_addr;
	logic [CNT_W-1:0]                  target;
	logic [CNT_W-1:0]                  bursts_done;

	// Bank traffic
	bank_wr_s                          bank_wr;
	logic [NUM_BANKS-1:0]              bank_full;
	logic [NUM_BANKS-1:0][WORD_W-1:0]  bank_rd_data;
	logic [BANK_AW-1:0]                rd_addr;
	logic                              rd_ena;
	logic [NUM_BANKS-1:0]              release_req;

	cap_regs u_regs (
		.clk         (clk),
		.cap_run     (cap_run),
		.bus         (bus),
		.rdata       (rdata),
		.ack         (ack),
		.bursts_done (bursts_done),
		.overrun     (overrun),
		.done_pulse  (done_pulse),
		.capturing   (capturing),
		.start_pulse (start_pulse),
		.base_addr   (base_addr),
		.target      (target)
	);

	sync_capture u_front (
		.clk       (clk),
		.cap_run   (cap_run),
		.capturing (capturing),
		.vid_data  (vid_data),
		.bank_full (bank_full),
		.bank_wr   (bank_wr),
		.overrun   (overrun)
	);

	for (genvar i = 0; i < NUM_BANKS; i++)
	begin : g_bank
		line_bank #(
			.BANK_ID (i)
		) u_bank (
			.clk         (clk),
			.cap_run     (cap_run),
			.wr          (bank_wr),
			.rd_addr     (rd_addr),
			.rd_ena      (rd_ena),
			.release_req (release_req[i]),
			.rd_data     (bank_rd_data[i]),
			.full        (bank_full[i])
		);
	end

	burst_flush u_flush (
		.clk          (clk),
		.cap_run      (cap_run),
		.start_pulse  (start_pulse),
		.base_addr    (base_addr),
		.target       (target),
		.bank_full    (bank_full),
		.bank_rd_data (bank_rd_data),
		.rd_addr      (rd_addr),
		.rd_ena       (rd_ena),
		.release_req  (release_req),
		.mem_req      (mem_req),
		.mem_ready    (mem_ready),
		.mem_wdata    (mem_wdata),
		.mem_wack     (mem_wack),
		.mem_wlast    (mem_wlast),
		.bursts_done  (bursts_done),
		.done_pulse   (done_pulse)
	);

endmodule

// File: tests/vid_cap_assert.sv
`timescale 1ns/1ps

module vid_cap_assert (
	input logic                          clk,
	input logic                          cap_run,
	input mem_pkg::mem_req_s             mem_req,
	input logic                          mem_ready,
	input logic                          mem_wack,
	input logic                          ack,
	input logic                          capturing,
	input logic                          overrun,
	input logic [cap_pkg::NUM_BANKS-1:0] bank_full
);

	int assert_fails = 0;

	// Command held with a steady address until taken
	a_req_hold: assert property (@(posedge clk) disable iff (!cap_run)
		(mem_req.valid && !mem_ready) |=> (mem_req.valid && $stable(mem_req.addr)))
	else
	begin
		assert_fails++;
		$error("memory command dropped or moved before ready");
	end

	a_ack_pulse: assert property (@(posedge clk) disable iff (!cap_run)
		ack |=> !ack)
	else
	begin
		assert_fails++;
		$error("register ack longer than one cycle");
	end

	// First edge out of reset
	a_reset_idle: assert property (@(posedge clk)
		$rose(cap_run) |-> (!mem_req.valid && !ack && !capturing && !overrun &&
			(bank_full == '0)))
	else
	begin
		assert_fails++;
		$error("outputs not idle after reset");
	end

	a_wack_gap: assert property (@(posedge clk) disable iff (!cap_run)
		(mem_req.valid && mem_ready) |=> !mem_wack)
	else
	begin
		assert_fails++;
		$error("write ack in the cycle right after acceptance");
	end

endmodule

bind vid_cap_top vid_cap_assert u_assert (
	.clk       (clk),
	.cap_run   (cap_run),
	.mem_req   (mem_req),
	.mem_ready (mem_ready),
	.mem_wack  (mem_wack),
	.ack       (ack),
	.capturing (capturing),
	.overrun   (overrun),
	.bank_full (bank_full)
);

// File: tests/tb_vid_cap.sv
`timescale 1ns/1ps

module tb_vid_cap;
	import mem_pkg::*;
	import cap_pkg::*;

	localparam int CLK_HALF_NS  = 4;
	localparam int RESET_CYCLES = 16;
	localparam int ACK_TMO      = 20;
	localparam int POLL_TMO     = 20000;
	localparam int WATCHDOG     = 400000;
	localparam int QUIET_CYCLES = 300;

	localparam logic [DATA_W-1:0] ADDR_MASK = {{(DATA_W-ADDR_W){1'b0}}, {ADDR_W{1'b1}}};

	logic               clk;
	logic               cap_run;
	logic [PIXEL_W-1:0] vid_data;
	reg_bus_s           bus;
	logic [DATA_W-1:0]  rdata;
	logic               ack;
	mem_req_s           mem_req;
	logic               mem_ready;
	logic [DATA_W-1:0]  mem_wdata;
	logic               mem_wack;
	logic               mem_wlast;

	int check_errs;
	int timeout_errs;
	int quiet_errs = 0;

	// Memory model stall lengths in cycles
	int ready_min;
	int ready_max;
	int gap_max;

	// Words expected in memory order, and what the model received
	logic [WORD_W-1:0] exp_q[$];
	logic [WORD_W-1:0] rx_data_q[$];
	logic [ADDR_W-1:0] rx_addr_q[$];

	logic              quiet_watch;
	logic [ADDR_W-1:0] cmd_addr;
	logic [ADDR_W-1:0] cmd_idx;

	vid_cap_top i_dut (
		.clk       (clk),
		.cap_run   (cap_run),
		.vid_data  (vid_data),
		.bus       (bus),
		.rdata     (rdata),
		.ack       (ack),
		.mem_req   (mem_req),
		.mem_ready (mem_ready),
		.mem_wdata (mem_wdata),
		.mem_wack  (mem_wack),
		.mem_wlast (mem_wlast)
	);

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF_NS clk = ~clk;
	end

	initial
	begin : watchdog
		repeat (WATCHDOG) @(posedge clk);
		$display("simulation ran past its cycle limit");
		$display("Something failed");
		$finish;
	end

	// --------------------
	// Memory model
	// --------------------

	initial
	begin : mem_model
		int   delay;
		int   words;
		logic in_burst;
		mem_ready = 1'b0;
		mem_wack  = 1'b0;
		mem_wlast = 1'b0;
		in_burst  = 1'b0;
		delay     = 0;
		words     = 0;
		forever
		begin
			@(negedge clk);
			mem_wack  = 1'b0;
			mem_wlast = 1'b0;
			if (!cap_run)
			begin
				mem_ready = 1'b0;
				in_burst  = 1'b0;
				delay     = $urandom_range(ready_max, ready_min);
			end
			else if (!in_burst)
			begin
				// Valid gone while ready high means the command was taken
				if (mem_ready && !mem_req.valid)
				begin
					mem_ready = 1'b0;
					in_burst  = 1'b1;
					words     = 0;
					delay     = $urandom_range(gap_max, 0);
				end
				else if (mem_req.valid && !mem_ready)
				begin
					if (delay == 0)
						mem_ready = 1'b1;
					else
						delay--;
				end
			end
			else if (delay > 0)
				delay--;
			else
			begin
				mem_wack  = 1'b1;
				mem_wlast = (words == BURST_WORDS - 1);
				words++;
				if (words == BURST_WORDS)
				begin
					in_burst = 1'b0;
					delay    = $urandom_range(ready_max, ready_min);
				end
				else
					delay = $urandom_range(gap_max, 0);
			end
		end
	end

	// One stored entry per acknowledged word
	always @(posedge clk)
	begin
		if (cap_run)
		begin
			if (mem_req.valid && mem_ready)
			begin
				cmd_addr = mem_req.addr;
				cmd_idx  = '0;
			end
			if (mem_wack)
			begin
				rx_addr_q.push_back(cmd_addr + cmd_idx);
				rx_data_q.push_back(mem_wdata);
				cmd_idx = cmd_idx + 1'b1;
			end
			assert (!(quiet_watch && mem_req.valid))
			else
			begin
				quiet_errs++;
				$display("unexpected memory command at address %h", mem_req.addr);
			end
		end
	end

	// --------------------
	// Helpers
	// --------------------

	task automatic expect_equal(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp)
		else
		begin
			check_errs++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		cap_run = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		cap_run = 1'b1;
	endtask

	// Bus held until ack, then one more cycle so the write lands
	task automatic reg_access(input logic we, input logic [REG_AW-1:0] addr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] data);
		int t;
		t = 0;
		@(negedge clk);
		bus.cyc   = 1'b1;
		bus.we    = we;
		bus.addr  = addr;
		bus.wdata = wdata;
		@(negedge clk);
		while (!ack && t < ACK_TMO)
		begin
			@(negedge clk);
			t++;
		end
		if (!ack)
		begin
			timeout_errs++;
			$display("register bus gave no ack");
			data = '0;
		end
		else
			data = rdata;
		@(negedge clk);
		bus = '0;
	endtask

	task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [DATA_W-1:0] wdata);
		logic [DATA_W-1:0] unused;
		reg_access(1'b1, addr, wdata, unused);
	endtask

	task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [DATA_W-1:0] data);
		reg_access(1'b0, addr, '0, data);
	endtask

	task automatic start_capture(input logic [ADDR_W-1:0] base, input logic [15:0] bursts);
		reg_write(REG_BASE, {{(DATA_W-ADDR_W){1'b0}}, base});
		exp_q.delete();
		rx_data_q.delete();
		rx_addr_q.delete();
		reg_write(REG_CSR, {1'b1, 15'd0, bursts});
	endtask

	task automatic drive_byte(input logic [7:0] b);
		@(negedge clk);
		vid_data = b;
	endtask

	task automatic send_code(input logic [7:0] code);
		drive_byte(8'hff);
		drive_byte(8'h00);
		drive_byte(8'h00);
		drive_byte(code);
	endtask

	// Bytes below ff never form a timing code
	task automatic send_noise(input int n);
		for (int i = 0; i < n; i++)
			drive_byte(8'($urandom_range(254, 0)));
	endtask

	task automatic send_data(input int n);
		logic [7:0]  b;
		logic [31:0] word;
		word = '0;
		for (int i = 0; i < n; i++)
		begin
			b = 8'($urandom);
			drive_byte(b);
			// First byte ends up in bits 7:0
			word = {b, word[31:8]};
			if (i % 4 == 3)
				exp_q.push_back(word);
		end
		drive_byte(8'h00);
	endtask

	task automatic wait_idle();
		logic [DATA_W-1:0] csr;
		int                polls;
		polls = 0;
		reg_read(REG_CSR, csr);
		while (csr[31] && polls < POLL_TMO)
		begin
			reg_read(REG_CSR, csr);
			polls++;
		end
		if (csr[31])
		begin
			timeout_errs++;
			$display("capture still busy after the poll limit");
		end
	endtask

	task automatic check_capture(input logic [ADDR_W-1:0] base, input int bursts);
		logic [DATA_W-1:0] csr;
		int                n;
		n = bursts * BANK_WORDS;
		wait_idle();
		quiet_watch = 1'b1;
		repeat (QUIET_CYCLES) @(negedge clk);
		quiet_watch = 1'b0;
		reg_read(REG_CSR, csr);
		expect_equal("busy_clear", 32'd0, {31'd0, csr[31]});
		expect_equal("bursts_done", 32'(bursts), {16'd0, csr[15:0]});
		expect_equal("word_count", 32'(n), 32'(rx_data_q.size()));
		for (int i = 0; i < n && i < rx_data_q.size(); i++)
		begin
			expect_equal("burst_data", exp_q[i], rx_data_q[i]);
			expect_equal("burst_addr", 32'(base + ADDR_W'(i)), 32'(rx_addr_q[i]));
		end
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial
	begin : stimulus
		logic [DATA_W-1:0] rd;
		cap_run      = 1'b0;
		vid_data     = '0;
		bus          = '0;
		quiet_watch  = 1'b0;
		check_errs   = 0;
		timeout_errs = 0;
		ready_min    = 0;
		ready_max    = 8;
		gap_max      = 3;
		void'($urandom(32'h9fea_915a));

		// Register access
		apply_reset();
		reg_read(REG_CSR, rd);
		expect_equal("csr_after_reset", 32'd0, rd);
		reg_write(REG_BASE, 32'hffc5_a5a5);
		reg_read(REG_BASE, rd);
		expect_equal("base_readback", 32'hffc5_a5a5 & ADDR_MASK, rd);

		// Active code before blanking must be ignored
		apply_reset();
		start_capture(22'h00_4000, 16'd1);
		quiet_watch = 1'b1;
		send_code(SYNC_ACTIVE);
		send_noise(600);
		send_code(SYNC_VBLANK);
		send_noise(40);
		quiet_watch = 1'b0;
		send_code(SYNC_ACTIVE);
		send_data(BANK_WORDS * 4);
		check_capture(22'h00_4000, 1);

		// Long ready and wack stalls across two bursts
		ready_min = 100;
		ready_max = 400;
		gap_max   = 12;
		apply_reset();
		start_capture(22'h2a_b000, 16'd2);
		send_code(SYNC_VBLANK);
		send_noise(25);
		send_code(SYNC_ACTIVE);
		send_data(2 * BANK_WORDS * 4);
		check_capture(22'h2a_b000, 2);

		// Memory stalled past both banks
		ready_min = 5000;
		ready_max = 5000;
		gap_max   = 0;
		apply_reset();
		start_capture(22'h10_0000, 16'd4);
		send_code(SYNC_VBLANK);
		send_noise(10);
		send_code(SYNC_ACTIVE);
		send_data(NUM_BANKS * BANK_WORDS * 4 + 64);
		reg_read(REG_CSR, rd);
		expect_equal("overrun", 32'd1, {31'd0, rd[30]});
		apply_reset();

		$display("errors: checks=%0d quiet=%0d timeouts=%0d assertions=%0d",
			check_errs, quiet_errs, timeout_errs, i_dut.u_assert.assert_fails);
		if (check_errs == 0 && quiet_errs == 0 && timeout_errs == 0 &&
				i_dut.u_assert.assert_fails == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: sim.f
source/mem_pkg.sv
source/cap_pkg.sv
source/line_bank.sv
source/sync_capture.sv
source/burst_flush.sv
source/cap_regs.sv
source/vid_cap_top.sv
tests/vid_cap_assert.sv
tests/tb_vid_cap.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vid_cap
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
